// File: logic/dpc_pkg.sv
//////////////////////////////
// shared widths, message codes and beat types for the DMA path controller
// imported by every RTL block and by the testbench
//////////////////////////////

package dpc_pkg;

	//////////////////////////////
	// sizes
	//////////////////////////////
	localparam int num_ports = 4;              // FPU requesters on the ingress path
	localparam int beat_w = 128;
	localparam int len_w = 16;
	localparam int fifo_depth = 16;            // ingress FIFO entries
	localparam int fifo_ptr_w = $clog2(fifo_depth);

	// message type codes in the header
	localparam logic [7:0] msg_read = 8'h01;
	localparam logic [7:0] msg_write = 8'h03;

	typedef logic [1:0] port_idx_t;

	//////////////////////////////
	// header layout
	//////////////////////////////
	// length on top, DRAM address at the bottom
	typedef struct packed {
		logic [len_w-1:0] length;             // beats in the frame, header included
		logic [15:0]      dpram_addr;
		logic [39:0]      dram_addr;
	} dma_cmd_t;

	typedef struct packed {
		logic [47:0] reserved;
		logic [7:0]  msg_type;
		dma_cmd_t    cmd;
	} dma_header_t;

	// one beat seen as a header or as plain payload
	typedef union packed {
		dma_header_t      header;
		logic [beat_w-1:0] raw;
	} dma_beat_u;

	// what the dispatcher does with a FIFO entry
	typedef enum logic [1:0] {
		tag_read_cmd,
		tag_write_cmd,
		tag_payload,
		tag_discard
	} beat_tag_e;

	typedef struct packed {
		beat_tag_e tag;
		dma_beat_u beat;
	} beat_entry_t;

	//////////////////////////////
	// requester side
	//////////////////////////////
	typedef struct packed {
		logic      req;                       // held until resp
		logic      write_valid;
		dma_beat_u write_data;
	} fpu_req_t;

	typedef struct packed {
		logic resp;                           // grant strobe, drops on header
		logic write_ready;
	} fpu_rsp_t;

endpackage

// File: logic/token_arbiter.sv
//////////////////////////////
// round-robin token arbiter for the FPU requesters
// grants one port until the frame counter reports the frame done
//////////////////////////////
`timescale 1ns/1ps

module token_arbiter import dpc_pkg::*; (
	input  logic                       fpu_clk,
	input  logic                       reset,
	input  fpu_req_t [num_ports-1:0]   fpu_in,
	output fpu_rsp_t [num_ports-1:0]   fpu_out,
	input  logic                       resp,
	input  logic                       accept,
	input  logic                       frame_done,
	output logic                       granted,
	output fpu_req_t                   sel_req
);

	// search states name the port the scan starts from
	typedef enum logic [2:0] {
		st_search0 = 3'd0,
		st_search1 = 3'd1,
		st_search2 = 3'd2,
		st_search3 = 3'd3,
		st_held    = 3'd4
	} arb_state_e;

	arb_state_e             state;
	logic [num_ports-1:0]   grant_oh;    // one-hot, only in st_held
	port_idx_t              sel_idx;
	port_idx_t              start_idx;
	port_idx_t              next_start;
	port_idx_t              pick;
	logic                   found;

	assign start_idx = state[1:0];
	assign next_start = sel_idx + 2'd1;  // wraps after port 3

	//////////////////////////////
	// pick first requester from start_idx
	//////////////////////////////
	always_comb begin
		found = 1'b0;
		pick = start_idx;
		// scan backwards so the smallest offset wins
		for (int i = num_ports - 1; i >= 0; i--) begin
			if (fpu_in[port_idx_t'(start_idx + i)].req) begin
				found = 1'b1;
				pick = port_idx_t'(start_idx + i);
			end
		end
	end

	always_ff @(posedge fpu_clk or posedge reset) begin
		if (reset) begin
			state <= st_search0;
			grant_oh <= '0;
			sel_idx <= '0;
		end else begin
			case (state)
				st_held: begin
					if (frame_done) begin
						grant_oh <= '0;  // at least one idle cycle follows
						state <= arb_state_e'({1'b0, next_start});
					end
				end
				default: begin
					// stay on the same start port while nobody asks
					if (found) begin
						grant_oh <= {{(num_ports-1){1'b0}}, 1'b1} << pick;
						sel_idx <= pick;
						state <= st_held;
					end
				end
			endcase
		end
	end

	assign granted = |grant_oh;

	// muxed requester, quiet when no grant
	assign sel_req = granted ? fpu_in[sel_idx] : '0;

	//////////////////////////////
	// steer strobes to the owner only
	//////////////////////////////
	always_comb begin
		for (int p = 0; p < num_ports; p++) begin
			fpu_out[p].resp = grant_oh[p] & resp;
			fpu_out[p].write_ready = grant_oh[p] & accept;
		end
	end

endmodule

// File: logic/frame_counter.sv
//////////////////////////////
// frame tracking for the granted requester
// raises resp, classifies the header, tags and counts every beat
//////////////////////////////
`timescale 1ns/1ps

module frame_counter import dpc_pkg::*; (
	input  logic        fpu_clk,
	input  logic        reset,
	input  logic        granted,
	input  fpu_req_t    sel_req,
	input  logic        full,
	output logic        resp,
	output logic        accept,
	output logic        frame_done,
	output logic        push,
	output beat_entry_t push_entry
);

	typedef enum logic [1:0] {
		fc_idle,
		fc_header,     // resp high, waiting for the header beat
		fc_body,       // payload beats of a write frame
		fc_done
	} fc_state_e;

	fc_state_e          state;
	logic [len_w-1:0]   beat_cnt;    // beats taken so far, header included
	logic [len_w-1:0]   frame_len;
	dma_header_t        hdr;
	logic               is_read;
	logic               is_write;
	logic               xfer;
	beat_tag_e          hdr_tag;

	//////////////////////////////
	// header decode
	//////////////////////////////
	assign hdr = sel_req.write_data.header;
	assign is_read = (hdr.msg_type == msg_read);
	// a write needs at least one payload beat
	assign is_write = (hdr.msg_type == msg_write) && (hdr.cmd.length >= len_w'(2));

	always_comb begin
		if (is_read)
			hdr_tag = tag_read_cmd;
		else if (is_write)
			hdr_tag = tag_write_cmd;
		else
			hdr_tag = tag_discard;  // unknown type, one-beat frame
	end

	//////////////////////////////
	// handshake with the requester
	//////////////////////////////
	assign resp = (state == fc_header);
	assign accept = ((state == fc_header) || (state == fc_body)) && !full;
	assign xfer = accept & sel_req.write_valid;
	assign frame_done = (state == fc_done);

	assign push = xfer;
	assign push_entry.tag = (state == fc_header) ? hdr_tag : tag_payload;
	assign push_entry.beat = sel_req.write_data;

	always_ff @(posedge fpu_clk or posedge reset) begin
		if (reset) begin
			state <= fc_idle;
			beat_cnt <= '0;
			frame_len <= '0;
		end else begin
			case (state)
				fc_idle: begin
					if (granted)
						state <= fc_header;
				end
				fc_header: begin
					if (xfer) begin
						beat_cnt <= len_w'(1);
						frame_len <= hdr.cmd.length;
						state <= is_write ? fc_body : fc_done;
					end
				end
				fc_body: begin
					if (xfer) begin
						beat_cnt <= beat_cnt + 1'b1;
						if (len_w'(beat_cnt + 1'b1) == frame_len)
							state <= fc_done;  // last payload beat
					end
				end
				default: begin
					state <= fc_idle;  // frame_done pulse
				end
			endcase
		end
	end

endmodule

// File: logic/beat_fifo.sv
//////////////////////////////
// ingress FIFO of tagged beats
// register array, head readable without a pop
//////////////////////////////
`timescale 1ns/1ps

module beat_fifo import dpc_pkg::*; (
	input  logic        fpu_clk,
	input  logic        reset,
	input  logic        push,
	input  beat_entry_t push_entry,
	input  logic        pop,
	output beat_entry_t head,
	output logic        empty,
	output logic        full
);

	beat_entry_t            mem [fifo_depth];
	logic [fifo_ptr_w-1:0]  wr_ptr;
	logic [fifo_ptr_w-1:0]  rd_ptr;
	logic [fifo_ptr_w:0]    count;       // one extra bit to hold fifo_depth
	logic                   do_push;
	logic                   do_pop;

	assign empty = (count == '0);
	assign full = (count == (fifo_ptr_w + 1)'(fifo_depth));

	// out-of-range requests are dropped
	assign do_push = push && !full;
	assign do_pop = pop && !empty;

	assign head = mem[rd_ptr];

	//////////////////////////////
	// storage
	//////////////////////////////
	always_ff @(posedge fpu_clk) begin
		if (do_push)
			mem[wr_ptr] <= push_entry;
	end

	always_ff @(posedge fpu_clk or posedge reset) begin
		if (reset) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
		end else begin
			if (do_push)
				wr_ptr <= wr_ptr + 1'b1;  // depth is a power of two
			if (do_pop)
				rd_ptr <= rd_ptr + 1'b1;
			case ({do_push, do_pop})
				2'b10: count <= count + 1'b1;
				2'b01: count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

endmodule

// File: logic/command_dispatcher.sv
//////////////////////////////
// drains the ingress FIFO head by its tag
// read headers go to the rcc port, write payload to the wcc stream
//////////////////////////////
`timescale 1ns/1ps

module command_dispatcher import dpc_pkg::*; (
	input  logic              fpu_clk,
	input  logic              reset,
	input  beat_entry_t       head,
	input  logic              empty,
	output logic              pop,
	input  logic              rcc_ready,
	output dma_cmd_t          rcc_cmd,
	output logic              rcc_valid,
	input  logic              wcc_ready,
	output dma_cmd_t          wcc_cmd,
	output logic [beat_w-1:0] wcc_write_data,
	output logic              wcc_valid
);

	logic is_rd;
	logic is_wr_hdr;
	logic is_payload;
	logic is_drop;
	logic hold;          // write header or discard sat one cycle at head
	logic rd_go;
	logic pay_go;

	//////////////////////////////
	// head decode
	//////////////////////////////
	assign is_rd = !empty && (head.tag == tag_read_cmd);
	assign is_wr_hdr = !empty && (head.tag == tag_write_cmd);
	assign is_payload = !empty && (head.tag == tag_payload);
	assign is_drop = !empty && (head.tag == tag_discard);

	// read command leaves in the cycle rcc_ready is seen
	assign rd_go = is_rd && rcc_ready;
	assign rcc_valid = rd_go;
	assign rcc_cmd = head.beat.header.cmd;

	// payload waits on the sink
	assign wcc_valid = is_payload;
	assign wcc_write_data = head.beat.raw;
	assign pay_go = is_payload && wcc_ready;

	assign pop = rd_go | pay_go | hold;

	//////////////////////////////
	// write header and discard
	//////////////////////////////
	always_ff @(posedge fpu_clk or posedge reset) begin
		if (reset) begin
			hold <= 1'b0;
		end else begin
			// pop one cycle after arrival, then clear for the next entry
			if (!hold && (is_wr_hdr || is_drop))
				hold <= 1'b1;
			else
				hold <= 1'b0;
		end
	end

	// command for the payload beats that follow
	always_ff @(posedge fpu_clk or posedge reset) begin
		if (reset)
			wcc_cmd <= '0;
		else if (hold && is_wr_hdr)
			wcc_cmd <= head.beat.header.cmd;
	end

endmodule

// File: logic/dma_path_controller.sv
//////////////////////////////
// top of the DMA path controller
// arbiter, frame counter, ingress FIFO and dispatcher on fpu_clk
//////////////////////////////
`timescale 1ns/1ps

module dma_path_controller import dpc_pkg::*; (
	input  logic                     fpu_clk,
	input  logic                     reset,

	// FPU requesters
	input  fpu_req_t [num_ports-1:0] fpu_in,
	output fpu_rsp_t [num_ports-1:0] fpu_out,

	// read command port
	output dma_cmd_t                 rcc_cmd,
	output logic                     rcc_valid,
	input  logic                     rcc_ready,

	// write stream
	output dma_cmd_t                 wcc_cmd,
	output logic [beat_w-1:0]        wcc_write_data,
	output logic                     wcc_valid,
	input  logic                     wcc_ready
);

	//////////////////////////////
	// internal wires
	//////////////////////////////
	logic        granted;
	fpu_req_t    sel_req;
	logic        resp;
	logic        accept;
	logic        frame_done;
	logic        push;
	beat_entry_t push_entry;
	logic        full;
	beat_entry_t head;
	logic        empty;
	logic        pop;

	token_arbiter u_arbiter (
		.fpu_clk    (fpu_clk),
		.reset      (reset),
		.fpu_in     (fpu_in),
		.fpu_out    (fpu_out),
		.resp       (resp),
		.accept     (accept),
		.frame_done (frame_done),
		.granted    (granted),
		.sel_req    (sel_req)
	);

	frame_counter u_frame (
		.fpu_clk    (fpu_clk),
		.reset      (reset),
		.granted    (granted),
		.sel_req    (sel_req),
		.full       (full),
		.resp       (resp),
		.accept     (accept),
		.frame_done (frame_done),
		.push       (push),
		.push_entry (push_entry)
	);

	beat_fifo u_fifo (
		.fpu_clk    (fpu_clk),
		.reset      (reset),
		.push       (push),
		.push_entry (push_entry),
		.pop        (pop),
		.head       (head),
		.empty      (empty),
		.full       (full)
	);

	command_dispatcher u_dispatch (
		.fpu_clk        (fpu_clk),
		.reset          (reset),
		.head           (head),
		.empty          (empty),
		.pop            (pop),
		.rcc_ready      (rcc_ready),
		.rcc_cmd        (rcc_cmd),
		.rcc_valid      (rcc_valid),
		.wcc_ready      (wcc_ready),
		.wcc_cmd        (wcc_cmd),
		.wcc_write_data (wcc_write_data),
		.wcc_valid      (wcc_valid)
	);

endmodule

// File: test/dma_path_checker.sv
//////////////////////////////
// concurrent checks on the controller ports
// attached to every dma_path_controller by bind
//////////////////////////////
`timescale 1ns/1ps

module dma_path_checker import dpc_pkg::*; (
	input logic                     fpu_clk,
	input logic                     reset,
	input fpu_rsp_t [num_ports-1:0] fpu_out,
	input logic                     rcc_valid,
	input logic                     rcc_ready,
	input logic                     wcc_valid
);

	logic [num_ports-1:0] rsp_vec;
	logic [num_ports-1:0] wr_vec;
	logic [num_ports-1:0] owner;    // port whose resp was seen last

	always_comb begin
		for (int p = 0; p < num_ports; p++) begin
			rsp_vec[p] = fpu_out[p].resp;
			wr_vec[p] = fpu_out[p].write_ready;
		end
	end

	always_ff @(posedge fpu_clk or posedge reset) begin
		if (reset)
			owner <= '0;
		else if (|rsp_vec)
			owner <= rsp_vec;
	end

	resp_onehot: assert property (@(posedge fpu_clk) disable iff (reset) $onehot0(rsp_vec))
		else $error("more than one requester sees resp");

	// ready may only go to the port that got resp
	ready_owner: assert property (@(posedge fpu_clk) disable iff (reset)
		(wr_vec & ~(owner | rsp_vec)) == '0)
		else $error("write_ready given to a port without resp");

	rcc_handshake: assert property (@(posedge fpu_clk) disable iff (reset)
		rcc_valid |-> rcc_ready)
		else $error("rcc_valid raised while rcc_ready is low");

	reset_quiet: assert property (@(posedge fpu_clk)
		reset |-> (rsp_vec == '0 && wr_vec == '0 && !rcc_valid && !wcc_valid))
		else $error("output strobe active during reset");

endmodule

bind dma_path_controller dma_path_checker u_checker (.*);

// File: test/dma_path_tb.sv
//////////////////////////////
// testbench for the DMA path controller
// frame table through four requester models, rcc and wcc sinks
//////////////////////////////
`timescale 1ns/1ps

module dma_path_tb import dpc_pkg::*; ();

	localparam int n_rows = 12;
	localparam int max_beats = 24;

	typedef struct {
		string       name;
		port_idx_t   port;
		logic [7:0]  msg_type;
		logic [15:0] length;
		logic [39:0] dram_addr;
		logic [15:0] dpram_addr;
	} frame_row_t;

	// name, port, type, length, dram, dpram
	frame_row_t rows [n_rows] = '{
		'{"rr_read_p0",    2'd0, msg_read,  16'd1,  40'h00_0000_1000, 16'h0010},
		'{"rr_write_p1",   2'd1, msg_write, 16'd4,  40'h00_0000_2000, 16'h0020},
		'{"rr_read_p2",    2'd2, msg_read,  16'd1,  40'h00_0000_3000, 16'h0030},
		'{"rr_write_p3",   2'd3, msg_write, 16'd3,  40'h00_0000_4000, 16'h0040},
		'{"unknown_p1",    2'd1, 8'h7e,     16'd5,  40'h00_0000_5000, 16'h0050},
		'{"write_len1_p2", 2'd2, msg_write, 16'd1,  40'h00_0000_6000, 16'h0060},
		'{"read_p3",       2'd3, msg_read,  16'd1,  40'h00_0000_7000, 16'h0070},
		'{"read_p1",       2'd1, msg_read,  16'd1,  40'h00_0000_8000, 16'h0080},
		'{"fill_p0",       2'd0, msg_write, 16'd20, 40'h00_0000_9000, 16'h0090},
		'{"write_p2",      2'd2, msg_write, 16'd5,  40'h00_0000_a000, 16'h00a0},
		'{"read_p0",       2'd0, msg_read,  16'd1,  40'h00_0000_b000, 16'h00b0},
		'{"write_p3",      2'd3, msg_write, 16'd2,  40'h00_0000_c000, 16'h00c0}
	};

	logic                     fpu_clk;
	logic                     reset;
	fpu_req_t [num_ports-1:0] fpu_in;
	fpu_rsp_t [num_ports-1:0] fpu_out;
	dma_cmd_t                 rcc_cmd;
	logic                     rcc_valid;
	logic                     rcc_ready;
	dma_cmd_t                 wcc_cmd;
	logic [beat_w-1:0]        wcc_write_data;
	logic                     wcc_valid;
	logic                     wcc_ready;

	dma_beat_u payload [n_rows][max_beats];
	int        exp_rd[$];                   // rows owing one read command
	int        exp_wr_row[$];
	int        exp_wr_beat[$];
	int        last_row [num_ports];
	port_idx_t rr_start;                    // first port the next grant may go to
	logic [num_ports-1:0] resp_q;
	logic      stall_wcc;
	logic      saw_full;
	int        grant_cnt;
	int        total_beats;
	int        seed;

	dma_path_controller UUT (.*);

	always #50 fpu_clk = ~fpu_clk;

	function automatic dma_cmd_t row_cmd(input int r);
		dma_cmd_t c;
		c.length = rows[r].length;
		c.dpram_addr = rows[r].dpram_addr;
		c.dram_addr = rows[r].dram_addr;
		return c;
	endfunction

	// header plus payload for a real write, header alone otherwise
	function automatic int frame_beats(input int r);
		if (rows[r].msg_type == msg_write && rows[r].length >= 2)
			return rows[r].length;
		return 1;
	endfunction

	task automatic stop_on_error(input string msg);
		$display("%s", msg);
		$display("Simulation failed");
		$fatal(1);
	endtask

	task automatic check_cmd(input string name, input dma_cmd_t exp, input dma_cmd_t act);
		if (exp !== act)
			stop_on_error($sformatf("mismatch in %s: expected %h, actual %h", name, exp, act));
	endtask

	task automatic check_beat(input string name, input dma_beat_u exp, input dma_beat_u act);
		if (exp !== act)
			stop_on_error($sformatf("mismatch in %s: expected %h, actual %h", name, exp, act));
	endtask

	task automatic check_port(input string name, input port_idx_t exp, input port_idx_t act);
		if (exp !== act)
			stop_on_error($sformatf("mismatch in %s: expected port %0d, actual port %0d",
				name, exp, act));
	endtask

	//////////////////////////////
	// requester model
	//////////////////////////////
	task automatic send_frame(input int p, input int r);
		dma_beat_u hdr;
		hdr.header.reserved = '0;
		hdr.header.msg_type = rows[r].msg_type;
		hdr.header.cmd = row_cmd(r);
		fpu_in[p].req <= 1'b1;
		do @(posedge fpu_clk); while (!fpu_out[p].resp);
		fpu_in[p].req <= 1'b0;
		for (int b = 0; b < frame_beats(r); b++) begin
			fpu_in[p].write_valid <= 1'b1;
			fpu_in[p].write_data <= (b == 0) ? hdr : payload[r][b];
			do @(posedge fpu_clk); while (!fpu_out[p].write_ready);
		end
		fpu_in[p].write_valid <= 1'b0;
		repeat (3) @(posedge fpu_clk);  // gap before the next request
	endtask

	task automatic run_port(input int p);
		for (int r = 0; r < n_rows; r++)
			if (rows[r].port == p)
				send_frame(p, r);
	endtask

	// grant seen on port p: check order, queue what the frame owes
	task automatic on_grant(input int p);
		port_idx_t exp_p;
		port_idx_t q;
		logic      found;
		int        r;
		found = 1'b0;
		exp_p = rr_start;
		for (int i = 0; i < num_ports; i++) begin
			q = port_idx_t'(rr_start + i);
			if (!found && fpu_in[q].req) begin
				exp_p = q;
				found = 1'b1;
			end
		end
		r = last_row[p] + 1;
		while (r < n_rows && rows[r].port != p)
			r++;
		if (r >= n_rows) begin
			stop_on_error($sformatf("port %0d was granted with no frame left to send", p));
		end else begin
			check_port(rows[r].name, exp_p, port_idx_t'(p));
			last_row[p] = r;
			rr_start = port_idx_t'(p + 1);
			grant_cnt++;
			if (rows[r].msg_type == msg_read)
				exp_rd.push_back(r);
			for (int b = 1; b < frame_beats(r); b++) begin
				exp_wr_row.push_back(r);
				exp_wr_beat.push_back(b);
			end
			if (frame_beats(r) > fifo_depth)
				stall_wcc <= 1'b1;  // hold the sink until the FIFO fills
		end
	endtask

	//////////////////////////////
	// monitor and sinks
	//////////////////////////////
	always @(posedge fpu_clk) begin
		int r;
		int b;
		if (!reset) begin
			for (int p = 0; p < num_ports; p++) begin
				if (fpu_out[p].resp && !resp_q[p])
					on_grant(p);
				if (stall_wcc && fpu_in[p].write_valid && !fpu_out[p].write_ready) begin
					saw_full <= 1'b1;
					stall_wcc <= 1'b0;
				end
				resp_q[p] = fpu_out[p].resp;
			end
			if (rcc_valid) begin
				if (exp_rd.size() == 0) begin
					stop_on_error("read command came out with no read frame waiting for it");
				end else begin
					r = exp_rd.pop_front();
					check_cmd(rows[r].name, row_cmd(r), rcc_cmd);
				end
			end
			if (wcc_valid && wcc_ready) begin
				if (exp_wr_row.size() == 0) begin
					stop_on_error("write beat came out with no write payload waiting for it");
				end else begin
					r = exp_wr_row.pop_front();
					b = exp_wr_beat.pop_front();
					check_cmd(rows[r].name, row_cmd(r), wcc_cmd);
					check_beat(rows[r].name, payload[r][b], dma_beat_u'(wcc_write_data));
				end
			end
		end
	end

	always @(posedge fpu_clk) begin
		rcc_ready <= ($urandom % 4) != 0;  // mostly ready
		wcc_ready <= stall_wcc ? 1'b0 : 1'($urandom % 2);
	end

	initial begin
		seed = $urandom(3697);
		fpu_clk = 1'b0;
		reset = 1'b0;
		fpu_in = '0;
		rcc_ready = 1'b0;
		wcc_ready = 1'b0;
		resp_q = '0;
		stall_wcc = 1'b0;
		saw_full = 1'b0;
		grant_cnt = 0;
		rr_start = '0;
		total_beats = 0;
		for (int p = 0; p < num_ports; p++)
			last_row[p] = -1;
		for (int r = 0; r < n_rows; r++) begin
			total_beats += frame_beats(r);
			for (int b = 0; b < max_beats; b++)
				payload[r][b].raw = {$urandom, $urandom, $urandom, $urandom};
		end
		#1 reset = 1'b1;
		fork
			begin
				repeat (total_beats * 40 + 100) @(posedge fpu_clk);
				stop_on_error("timeout: the frames did not drain in time");
			end
		join_none
		repeat (5) @(posedge fpu_clk);
		reset <= 1'b0;
		fork
			run_port(0);
			run_port(1);
			run_port(2);
			run_port(3);
		join
		while (exp_rd.size() != 0 || exp_wr_row.size() != 0)
			@(posedge fpu_clk);
		repeat (20) @(posedge fpu_clk);  // catch late extra outputs
		if (grant_cnt != n_rows) begin
			stop_on_error($sformatf("saw %0d grants for %0d frames", grant_cnt, n_rows));
		end else if (!saw_full) begin
			stop_on_error("write_ready never dropped while the write stream was stalled");
		end else begin
			$display("Simulation passed");
			$finish;
		end
	end

endmodule

// File: verilog.f
logic/dpc_pkg.sv
logic/token_arbiter.sv
logic/frame_counter.sv
logic/beat_fifo.sv
logic/command_dispatcher.sv
logic/dma_path_controller.sv
test/dma_path_checker.sv
test/dma_path_tb.sv
